// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	// request and memory widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int BE_W = DATA_W / 8;

	// cache geometry
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int LINE_BEATS = 4;

	// address split
	// offset 4..0, dword select 4..3, index 8..5, tag 31..9
	localparam int OFFSET_W = 5;
	localparam int DW_LSB = 3;
	localparam int BEAT_W = 2;
	localparam int INDEX_LSB = 5;
	localparam int INDEX_W = 4;
	localparam int TAG_LSB = 9;
	localparam int TAG_W = 23;

	// backing memory defaults, top level may override
	localparam int MEM_LATENCY_DEF = 3;
	localparam int MEM_DWORDS_DEF = 1024;

	// perf counter width
	localparam int PERF_W = 32;

	// requester side, held stable until ready
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic wren;
		logic [DATA_W-1:0] din;
		logic [BE_W-1:0] be;
	} cache_req_t;

	// registered tag lookup result
	typedef struct packed {
		logic hit;
		logic [NUM_WAYS-1:0] way_hit;
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0] tag;
		logic [BEAT_W-1:0] dw_sel;
	} lookup_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		FILL_WAIT,
		FILL,
		REPLAY,
		RESPOND
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module tag_store (
	input wire clk,
	input wire rst,
	input wire dcache_pkg::cache_req_t req,
	input wire lookup_en,
	input wire inval_en,
	input wire install,
	input wire [dcache_pkg::NUM_WAYS-1:0] victim_way,
	output dcache_pkg::lookup_t lk
);
	import dcache_pkg::*;

	logic [INDEX_W-1:0] idx;
	logic [TAG_W-1:0] req_tag;
	logic [BEAT_W-1:0] dw_sel;
	logic [NUM_WAYS-1:0] way_hit;
	logic [NUM_WAYS-1:0] tag_match;

	// fields of the current request
	assign idx = req.addr[INDEX_LSB +: INDEX_W];
	assign req_tag = req.addr[TAG_LSB +: TAG_W];
	assign dw_sel = req.addr[DW_LSB +: BEAT_W];

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		// tag array of this way
		logic [TAG_W-1:0] tag_q [NUM_SETS];
		// one valid bit per set
		logic [NUM_SETS-1:0] valid_q;

		// raw tag compare, also used by store invalidation
		assign tag_match[w] = (tag_q[idx] == req_tag);
		assign way_hit[w] = valid_q[idx] && tag_match[w];

		// tag written once the refill has landed
		always_ff @(posedge clk) begin
			if (install && victim_way[w]) begin
				tag_q[idx] <= req_tag;
			end
		end

		always_ff @(posedge clk) begin
			if (rst) begin
				valid_q <= '0;
			end else if (install && victim_way[w]) begin
				valid_q[idx] <= 1'b1;
			end else if (inval_en && tag_match[w]) begin
				// store hits this line, drop it
				valid_q[idx] <= 1'b0;
			end
		end
	end

	// stage one result register
	always_ff @(posedge clk) begin
		if (rst) begin
			lk <= '0;
		end else if (lookup_en) begin
			lk.hit <= |way_hit;
			lk.way_hit <= way_hit;
			lk.index <= idx;
			lk.tag <= req_tag;
			lk.dw_sel <= dw_sel;
		end
	end

endmodule

`default_nettype wire

// ==== source/data_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_store (
	input wire clk,
	input wire dcache_pkg::cache_req_t req,
	input wire dcache_pkg::lookup_t lk,
	input wire rd_en,
	input wire fill_we,
	input wire [dcache_pkg::NUM_WAYS-1:0] fill_way,
	input wire [dcache_pkg::BEAT_W-1:0] beat,
	input wire [dcache_pkg::DATA_W-1:0] beat_data,
	output logic [dcache_pkg::DATA_W-1:0] dout
);
	import dcache_pkg::*;

	// one slot per doubleword of every set
	localparam int SLOT_W = INDEX_W + BEAT_W;
	localparam int SLOTS = NUM_SETS * LINE_BEATS;

	logic [INDEX_W-1:0] idx;
	logic [SLOT_W-1:0] rd_slot;
	logic [SLOT_W-1:0] wr_slot;
	logic [NUM_WAYS-1:0][DATA_W-1:0] way_dout;

	assign idx = req.addr[INDEX_LSB +: INDEX_W];
	// read picks the requested doubleword directly
	assign rd_slot = {idx, req.addr[DW_LSB +: BEAT_W]};
	// refill walks the beats of the same line
	assign wr_slot = {idx, beat};

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		logic [DATA_W-1:0] line_q [SLOTS];
		logic [DATA_W-1:0] rd_q;

		// only the victim way takes beats
		always_ff @(posedge clk) begin
			if (fill_we && fill_way[w]) begin
				line_q[wr_slot] <= beat_data;
			end
		end

		// stage two, all ways read in parallel
		always_ff @(posedge clk) begin
			if (rd_en) begin
				rd_q <= line_q[rd_slot];
			end
		end

		assign way_dout[w] = rd_q;
	end

	// response select
	// lk.way_hit is one-hot on a hit, so an or-mux is enough
	always_comb begin
		dout = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (lk.way_hit[w]) begin
				dout = dout | way_dout[w];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/miss_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module miss_ctrl (
	input wire clk,
	input wire rst,
	input wire dcache_pkg::cache_req_t req,
	input wire valid,
	input wire dcache_pkg::lookup_t lk,
	input wire beat_valid,
	input wire beat_last,
	output logic ready,
	output logic lookup_en,
	output logic inval_en,
	output logic install,
	output logic [dcache_pkg::NUM_WAYS-1:0] victim_way,
	output logic rd_en,
	output logic fill_we,
	output logic [dcache_pkg::NUM_WAYS-1:0] fill_way,
	output logic [dcache_pkg::BEAT_W-1:0] beat,
	output logic burst_req,
	output logic [dcache_pkg::ADDR_W-1:0] burst_addr,
	output logic mem_we,
	output logic [dcache_pkg::PERF_W-1:0] hit_count,
	output logic [dcache_pkg::PERF_W-1:0] miss_count
);
	import dcache_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_d;
	logic start;
	logic store_go;
	logic load_go;

	// new request, valid is ignored during the ready pulse
	assign start = (state == IDLE) && valid && !ready;
	assign store_go = start && req.wren;
	assign load_go = start && !req.wren;

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (store_go) begin
					state_d = RESPOND;
				end else if (load_go) begin
					state_d = LOOKUP;
				end
			end
			// lk holds the result of the edge that left IDLE
			LOOKUP: state_d = lk.hit ? IDLE : FILL_WAIT;
			FILL_WAIT, FILL: begin
				if (fill_we) begin
					state_d = beat_last ? REPLAY : FILL;
				end
			end
			REPLAY: state_d = RESPOND;
			RESPOND: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	// stage strobes
	assign lookup_en = load_go || (state == REPLAY);
	assign rd_en = (state == LOOKUP) || (state == REPLAY);
	// write through and invalidate together
	assign mem_we = store_go;
	assign inval_en = store_go;
	// every beat is taken in its own cycle
	assign fill_we = beat_valid && ((state == FILL_WAIT) || (state == FILL));
	assign install = fill_we && beat_last;
	assign fill_way = victim_way;
	// line aligned burst
	assign burst_addr = {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ready <= 1'b0;
			burst_req <= 1'b0;
		end else begin
			state <= state_d;
			// single cycle pulses
			ready <= ((state == LOOKUP) && lk.hit) || (state == RESPOND);
			burst_req <= (state == LOOKUP) && !lk.hit;
		end
	end

	// beat counter, cleared with the burst strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			beat <= '0;
		end else if (burst_req) begin
			beat <= '0;
		end else if (fill_we) begin
			beat <= beat + BEAT_W'(1);
		end
	end

	// victim rotator, moves once per completed fill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim_way <= NUM_WAYS'(1);
		end else if (install) begin
			victim_way <= {victim_way[NUM_WAYS-2:0], victim_way[NUM_WAYS-1]};
		end
	end

	// first lookup only, replay is not counted
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_count <= '0;
			miss_count <= '0;
		end else if (state == LOOKUP) begin
			if (lk.hit) begin
				hit_count <= hit_count + PERF_W'(1);
			end else begin
				miss_count <= miss_count + PERF_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/main_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module main_mem #(
	parameter int MEM_LATENCY = dcache_pkg::MEM_LATENCY_DEF,
	parameter int MEM_DWORDS = dcache_pkg::MEM_DWORDS_DEF
) (
	input wire clk,
	input wire rst,
	input wire we,
	input wire [dcache_pkg::ADDR_W-1:0] addr,
	input wire [dcache_pkg::DATA_W-1:0] wdata,
	input wire [dcache_pkg::BE_W-1:0] be,
	input wire burst_req,
	input wire [dcache_pkg::ADDR_W-1:0] burst_addr,
	output logic beat_valid,
	output logic beat_last,
	output logic [dcache_pkg::DATA_W-1:0] beat_data
);
	import dcache_pkg::*;

	// dword index bits, upper address bits wrap
	localparam int MW = $clog2(MEM_DWORDS);
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	logic [DATA_W-1:0] mem [MEM_DWORDS];
	logic [MW-1:0] wr_idx;
	logic [MW-BEAT_W-1:0] line_q;
	logic [LAT_W-1:0] wait_cnt;
	logic waiting;
	logic streaming;
	logic [BEAT_W-1:0] beat_idx;

	assign wr_idx = addr[DW_LSB +: MW];

	// byte masked single write
	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < BE_W; b++) begin
				if (be[b]) begin
					mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	// line number latched at the strobe
	always_ff @(posedge clk) begin
		if (burst_req) begin
			line_q <= burst_addr[OFFSET_W +: MW-BEAT_W];
		end
	end

	// beat payload
	always_ff @(posedge clk) begin
		if (streaming) begin
			beat_data <= mem[{line_q, beat_idx}];
		end
	end

	// latency wait, then four consecutive beats
	always_ff @(posedge clk) begin
		if (rst) begin
			waiting <= 1'b0;
			streaming <= 1'b0;
			wait_cnt <= '0;
			beat_idx <= '0;
			beat_valid <= 1'b0;
			beat_last <= 1'b0;
		end else begin
			beat_valid <= 1'b0;
			beat_last <= 1'b0;
			if (burst_req) begin
				waiting <= 1'b1;
				wait_cnt <= LAT_W'(MEM_LATENCY);
			end else if (waiting) begin
				wait_cnt <= wait_cnt - LAT_W'(1);
				if (wait_cnt == LAT_W'(1)) begin
					waiting <= 1'b0;
					streaming <= 1'b1;
					beat_idx <= '0;
				end
			end else if (streaming) begin
				beat_valid <= 1'b1;
				beat_last <= (beat_idx == BEAT_W'(LINE_BEATS - 1));
				beat_idx <= beat_idx + BEAT_W'(1);
				if (beat_idx == BEAT_W'(LINE_BEATS - 1)) begin
					streaming <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
	parameter int MEM_LATENCY = dcache_pkg::MEM_LATENCY_DEF,
	parameter int MEM_DWORDS = dcache_pkg::MEM_DWORDS_DEF
) (
	input wire clk,
	input wire rst,
	input wire valid,
	input wire [dcache_pkg::ADDR_W-1:0] addr,
	input wire wren,
	input wire [dcache_pkg::DATA_W-1:0] din,
	input wire [dcache_pkg::BE_W-1:0] be,
	output logic ready,
	output logic [dcache_pkg::DATA_W-1:0] dout,
	output logic [dcache_pkg::PERF_W-1:0] hit_count,
	output logic [dcache_pkg::PERF_W-1:0] miss_count
);
	import dcache_pkg::*;

	// request bundle seen by every stage
	cache_req_t req;
	lookup_t lk;

	logic lookup_en;
	logic inval_en;
	logic install;
	logic [NUM_WAYS-1:0] victim_way;
	logic rd_en;
	logic fill_we;
	logic [NUM_WAYS-1:0] fill_way;
	logic [BEAT_W-1:0] beat;
	logic burst_req;
	logic [ADDR_W-1:0] burst_addr;
	logic mem_we;
	// refill stream from memory
	logic beat_valid;
	logic beat_last;
	logic [DATA_W-1:0] beat_data;

	assign req = '{addr: addr, wren: wren, din: din, be: be};

	tag_store u_tag (.clk, .rst, .req, .lookup_en, .inval_en, .install, .victim_way, .lk);

	data_store u_data (.clk, .req, .lk, .rd_en, .fill_we, .fill_way, .beat, .beat_data, .dout);

	miss_ctrl u_ctrl (
		.clk, .rst, .req, .valid, .lk, .beat_valid, .beat_last,
		.ready, .lookup_en, .inval_en, .install, .victim_way,
		.rd_en, .fill_we, .fill_way, .beat,
		.burst_req, .burst_addr, .mem_we, .hit_count, .miss_count
	);

	// stores go straight through to the backing memory
	main_mem #(
		.MEM_LATENCY(MEM_LATENCY),
		.MEM_DWORDS(MEM_DWORDS)
	) u_mem (
		.clk, .rst,
		.we(mem_we), .addr(req.addr), .wdata(req.din), .be(req.be),
		.burst_req, .burst_addr, .beat_valid, .beat_last, .beat_data
	);

endmodule

`default_nettype wire

// ==== verification/dcache_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache_chk (
	input wire clk,
	input wire rst,
	input wire ready,
	input wire [dcache_pkg::DATA_W-1:0] dout,
	input wire dcache_pkg::lookup_t lk,
	input wire burst_req,
	input wire beat_valid,
	input wire beat_last
);
	// count of failed properties
	int fails = 0;
	logic fill_busy;

	// burst outstanding from its strobe up to the last beat
	always_ff @(posedge clk) begin
		if (rst) begin
			fill_busy <= 1'b0;
		end else if (burst_req) begin
			fill_busy <= 1'b1;
		end else if (beat_valid && beat_last) begin
			fill_busy <= 1'b0;
		end
	end

	// ready is a one cycle pulse
	ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else begin
			$error("ready stayed high for two cycles");
			fails++;
		end

	// lookup result never hits two ways
	one_way: assert property (@(posedge clk) disable iff (rst) $onehot0(lk.way_hit))
		else begin
			$error("more than one way hit in the lookup result");
			fails++;
		end

	// no new burst while a refill is still running
	burst_free: assert property (@(posedge clk) disable iff (rst) burst_req |-> !fill_busy)
		else begin
			$error("burst requested during an active fill");
			fails++;
		end

	dout_known: assert property (@(posedge clk) disable iff (rst) ready |-> !$isunknown(dout))
		else begin
			$error("dout unknown while ready is high");
			fails++;
		end

endmodule

`default_nettype wire

// ==== verification/tb_dcache.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int MEM_DWORDS = 1024;
	localparam int MW = $clog2(MEM_DWORDS);
	localparam int RAND_OPS = 300;
	// 8 + 4 + 2 + 15 directed requests, then the random ones
	localparam int NUM_REQS = 29 + RAND_OPS;
	// line for the directed tests, index 0
	localparam logic [ADDR_W-1:0] LINE_A = 32'h0000_0400;
	// index 3, second doubleword
	localparam logic [ADDR_W-1:0] CONFLICT = 32'h0000_0068;
	// 2 KiB window for random traffic
	localparam logic [ADDR_W-1:0] WINDOW = 32'h0000_1000;

	logic clk = 1'b0;
	logic rst;
	logic valid;
	logic [ADDR_W-1:0] addr;
	logic wren;
	logic [DATA_W-1:0] din;
	logic [BE_W-1:0] be;
	logic ready;
	logic [DATA_W-1:0] dout;
	logic [PERF_W-1:0] hit_count;
	logic [PERF_W-1:0] miss_count;

	// expected memory image
	logic [DATA_W-1:0] shadow [MEM_DWORDS];
	bit written [MEM_DWORDS];
	logic [31:0] rng;
	int loads;

	dcache_top #(
		.MEM_LATENCY(3),
		.MEM_DWORDS(MEM_DWORDS)
	) DUT (
		.clk, .rst, .valid, .addr, .wren, .din, .be,
		.ready, .dout, .hit_count, .miss_count
	);

	bind dcache_top dcache_chk u_chk (
		.clk, .rst, .ready, .dout, .lk, .burst_req, .beat_valid, .beat_last
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// two steps per doubleword
	task automatic rand_dword(output logic [DATA_W-1:0] r);
		rng = xorshift(rng);
		r[63:32] = rng;
		rng = xorshift(rng);
		r[31:0] = rng;
	endtask

	// bytes enabled in m come from new_d
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_d,
			input logic [DATA_W-1:0] new_d, input logic [BE_W-1:0] m);
		logic [DATA_W-1:0] r;
		r = old_d;
		for (int b = 0; b < BE_W; b++) begin
			if (m[b]) begin
				r[8*b +: 8] = new_d[8*b +: 8];
			end
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic expect_counts(input int hits, input int misses);
		check_value("hit_count", 64'(hit_count), 64'(hits));
		check_value("miss_count", 64'(miss_count), 64'(misses));
	endtask

	// one request, held until the ready pulse
	task automatic request(input logic [ADDR_W-1:0] a, input logic w,
			input logic [DATA_W-1:0] d, input logic [BE_W-1:0] m,
			output logic [DATA_W-1:0] rdata);
		valid = 1'b1;
		addr = a;
		wren = w;
		din = d;
		be = m;
		@(posedge clk);
		#1;
		while (!ready) begin
			@(posedge clk);
			#1;
		end
		rdata = dout;
		valid = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic store(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
			input logic [BE_W-1:0] m);
		logic [DATA_W-1:0] ignored;
		request(a, 1'b1, d, m, ignored);
		shadow[a[DW_LSB +: MW]] = merge_bytes(shadow[a[DW_LSB +: MW]], d, m);
		written[a[DW_LSB +: MW]] = 1'b1;
	endtask

	task automatic load_check(input logic [ADDR_W-1:0] a);
		logic [DATA_W-1:0] got;
		request(a, 1'b0, '0, '0, got);
		loads++;
		check_value("dout", got, shadow[a[DW_LSB +: MW]]);
	endtask

	// budget of 200 cycles per request
	initial begin
		#(NUM_REQS * 200 * CLK_PERIOD);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout, the cache stopped answering requests");
	end

	initial begin
		logic [DATA_W-1:0] d;
		logic [ADDR_W-1:0] a;
		logic [BE_W-1:0] m;
		logic op_store;
		rng = 32'h7c24;
		loads = 0;
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		wren = 1'b0;
		din = '0;
		be = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		check_value("ready", 64'(ready), 64'h0);
		expect_counts(0, 0);

		// fill one line by stores, then read it back
		for (int i = 0; i < LINE_BEATS; i++) begin
			rand_dword(d);
			store(LINE_A + ADDR_W'(8 * i), d, 8'hff);
		end
		for (int i = 0; i < LINE_BEATS; i++) begin
			load_check(LINE_A + ADDR_W'(8 * i));
		end
		expect_counts(3, 1);

		// same address again, all hits
		repeat (4) load_check(LINE_A + 32'h10);
		expect_counts(7, 1);

		// partial store drops the line
		rand_dword(d);
		store(LINE_A + 32'h18, d, 8'h3c);
		load_check(LINE_A + 32'h18);
		expect_counts(7, 2);

		// five lines on index 3, one more than the ways
		for (int k = 0; k < 5; k++) begin
			rand_dword(d);
			store(CONFLICT + (ADDR_W'(k) << TAG_LSB), d, 8'hff);
		end
		for (int r = 0; r < 2; r++) begin
			for (int k = 0; k < 5; k++) begin
				load_check(CONFLICT + (ADDR_W'(k) << TAG_LSB));
			end
		end

		for (int n = 0; n < RAND_OPS; n++) begin
			rng = xorshift(rng);
			a = WINDOW + (rng & 32'h0000_07f8);
			op_store = rng[31];
			m = rng[23:16];
			rand_dword(d);
			// first touch of a doubleword writes all of it
			if (!written[a[DW_LSB +: MW]]) begin
				op_store = 1'b1;
				m = 8'hff;
			end
			if (op_store) begin
				store(a, d, m);
			end else begin
				load_check(a);
			end
		end
		check_value("hit_count + miss_count", 64'(hit_count + miss_count), 64'(loads));

		if (DUT.u_chk.fails == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("SIMULATION FAILED");
			$fatal(1, "a protocol assertion in the checker failed");
		end
	end

endmodule

`default_nettype wire

// ==== all.f ====
source/dcache_pkg.sv
source/tag_store.sv
source/data_store.sv
source/miss_ctrl.sv
source/main_mem.sv
source/dcache_top.sv
verification/dcache_chk.sv
verification/tb_dcache.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_dcache with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_dcache -Mdir obj_dir -f all.f
	./obj_dir/Vtb_dcache

clean:
	rm -rf obj_dir
